// ==== rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    typedef logic [31:0] instrT;
    typedef logic [63:0] xlenT;
    typedef logic [4:0]  regIdxT;
    typedef logic [11:0] csrAddrT;

    // {muldiv, word, sub/arith, funct3}
    typedef logic [5:0]  aluCtlT;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        opLoad    = 5'b00000,
        opOpImm   = 5'b00100,
        opAuipc   = 5'b00101,
        opOpImm32 = 5'b00110,
        opStore   = 5'b01000,
        opOp      = 5'b01100,
        opLui     = 5'b01101,
        opOp32    = 5'b01110,
        opBranch  = 5'b11000,
        opJalr    = 5'b11001,
        opJal     = 5'b11011,
        opSystem  = 5'b11100
    } opcodeE;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ,
        immNone
    } immFmtE;

    typedef enum logic [3:0] {
        brNone,
        brJal,
        brJalr,
        brEq,
        brNe,
        brLt,
        brGe,
        brLtu,
        brGeu
    } branchE;

    typedef enum logic {
        aSrcReg,
        aSrcPc
    } aSrcE;

    typedef enum logic [1:0] {
        bSrcReg,
        bSrcFour,
        bSrcImm,
        bSrcCsr
    } bSrcE;

    typedef enum logic [2:0] {
        sysNone,
        sysEcall,
        sysEbreak,
        sysMret,
        sysCsr
    } sysOpE;

    // the only legal funct3 000 system words
    localparam instrT ecallWord  = 32'h0000_0073;
    localparam instrT ebreakWord = 32'h0010_0073;
    localparam instrT mretWord   = 32'h3020_0073;

endpackage

`default_nettype wire

// ==== idStagePkg.sv ====
`default_nettype none

package idStagePkg;

    // packet from fetch, 96 bits
    typedef struct packed {
        rvIsaPkg::instrT instr;
        rvIsaPkg::xlenT  pc;
    } fetchPktT;

    // control bundle handed to execute
    typedef struct packed {
        rvIsaPkg::xlenT    pc;
        rvIsaPkg::regIdxT  rd;
        rvIsaPkg::regIdxT  rs1;
        rvIsaPkg::regIdxT  rs2;
        rvIsaPkg::xlenT    imm;
        rvIsaPkg::aluCtlT  aluCtl;
        rvIsaPkg::aSrcE    aSrc;
        rvIsaPkg::bSrcE    bSrc;
        rvIsaPkg::branchE  branch;
        logic              memRd;
        logic              memWr;
        logic [2:0]        memOp;    // load/store funct3
        logic              regWr;
        rvIsaPkg::sysOpE   sysOp;
        rvIsaPkg::csrAddrT csrAddr;
        logic              illegal;
    } decodedT;

    // writeback retire notice
    typedef struct packed {
        logic             valid;
        rvIsaPkg::regIdxT rd;
    } wbNoticeT;

endpackage

`default_nettype wire

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  rvIsaPkg::instrT     instr,
    input  logic                csrBad,
    output idStagePkg::decodedT ctl,
    output rvIsaPkg::immFmtE    immFmt,
    output logic                useRs1,
    output logic                useRs2
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctl     = '0;
        ctl.rs1 = instr[19:15];
        ctl.rs2 = instr[24:20];
        immFmt  = rvIsaPkg::immNone;
        useRs1  = 1'b0;
        useRs2  = 1'b0;
        bad     = 1'b0;
        case (rvIsaPkg::opcodeE'(instr[6:2]))
            rvIsaPkg::opLoad: begin
                immFmt    = rvIsaPkg::immI;
                useRs1    = 1'b1;
                ctl.bSrc  = rvIsaPkg::bSrcImm;
                ctl.memRd = 1'b1;
                ctl.memOp = funct3;
                ctl.regWr = 1'b1;
                bad       = (funct3 == 3'b111);    // no ldu
            end
            rvIsaPkg::opStore: begin
                immFmt    = rvIsaPkg::immS;
                useRs1    = 1'b1;
                useRs2    = 1'b1;
                ctl.bSrc  = rvIsaPkg::bSrcImm;
                ctl.memWr = 1'b1;
                ctl.memOp = funct3;
                bad       = funct3[2];
            end
            rvIsaPkg::opOpImm, rvIsaPkg::opOpImm32: begin
                immFmt     = rvIsaPkg::immI;
                useRs1     = 1'b1;
                ctl.bSrc   = rvIsaPkg::bSrcImm;
                ctl.regWr  = 1'b1;
                ctl.aluCtl = {1'b0, instr[3], funct7[5] & (funct3 == 3'b101), funct3};
                if (!instr[3]) begin                         // 64-bit, 6-bit shamt
                    if (funct3 == 3'b001)
                        bad = (funct7[6:1] != 6'b000000);
                    else if (funct3 == 3'b101)
                        bad = (funct7[6:1] != 6'b000000) && (funct7[6:1] != 6'b010000);
                end else begin
                    case (funct3)
                        3'b000:  bad = 1'b0;
                        3'b001:  bad = (funct7 != 7'b0000000);
                        3'b101:  bad = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                        default: bad = 1'b1;
                    endcase
                end
            end
            rvIsaPkg::opOp, rvIsaPkg::opOp32: begin
                useRs1     = 1'b1;
                useRs2     = 1'b1;
                ctl.regWr  = 1'b1;
                ctl.aluCtl = {funct7[0], instr[3], funct7[5], funct3};
                case (funct7)
                    7'b0000000: bad = instr[3] && !(funct3 inside {3'b000, 3'b001, 3'b101});
                    7'b0100000: bad = !(funct3 inside {3'b000, 3'b101});    // sub, sra
                    7'b0000001: bad = instr[3] && (funct3 inside {3'b001, 3'b010, 3'b011});
                    default:    bad = 1'b1;
                endcase
            end
            rvIsaPkg::opLui: begin
                immFmt     = rvIsaPkg::immU;
                ctl.bSrc   = rvIsaPkg::bSrcImm;
                ctl.regWr  = 1'b1;
                ctl.aluCtl = 6'b00_1111;    // pass b
            end
            rvIsaPkg::opAuipc: begin
                immFmt    = rvIsaPkg::immU;
                ctl.aSrc  = rvIsaPkg::aSrcPc;
                ctl.bSrc  = rvIsaPkg::bSrcImm;
                ctl.regWr = 1'b1;
            end
            rvIsaPkg::opJal: begin
                immFmt     = rvIsaPkg::immJ;
                ctl.aSrc   = rvIsaPkg::aSrcPc;
                ctl.bSrc   = rvIsaPkg::bSrcFour;    // link = pc + 4
                ctl.branch = rvIsaPkg::brJal;
                ctl.regWr  = 1'b1;
            end
            rvIsaPkg::opJalr: begin
                immFmt     = rvIsaPkg::immI;
                useRs1     = 1'b1;
                ctl.aSrc   = rvIsaPkg::aSrcPc;
                ctl.bSrc   = rvIsaPkg::bSrcFour;
                ctl.branch = rvIsaPkg::brJalr;
                ctl.regWr  = 1'b1;
                bad        = (funct3 != 3'b000);
            end
            rvIsaPkg::opBranch: begin
                immFmt     = rvIsaPkg::immB;
                useRs1     = 1'b1;
                useRs2     = 1'b1;
                ctl.aluCtl = {5'b00001, funct3[1]};    // slt or sltu compare
                case (funct3)
                    3'b000:  ctl.branch = rvIsaPkg::brEq;
                    3'b001:  ctl.branch = rvIsaPkg::brNe;
                    3'b100:  ctl.branch = rvIsaPkg::brLt;
                    3'b101:  ctl.branch = rvIsaPkg::brGe;
                    3'b110:  ctl.branch = rvIsaPkg::brLtu;
                    3'b111:  ctl.branch = rvIsaPkg::brGeu;
                    default: bad = 1'b1;
                endcase
            end
            rvIsaPkg::opSystem: begin
                ctl.bSrc    = rvIsaPkg::bSrcCsr;
                ctl.aluCtl  = 6'b00_1111;
                ctl.csrAddr = instr[31:20];
                if (funct3 == 3'b000) begin
                    if (instr == rvIsaPkg::ecallWord)
                        ctl.sysOp = rvIsaPkg::sysEcall;
                    else if (instr == rvIsaPkg::ebreakWord)
                        ctl.sysOp = rvIsaPkg::sysEbreak;
                    else if (instr == rvIsaPkg::mretWord)
                        ctl.sysOp = rvIsaPkg::sysMret;
                    else
                        bad = 1'b1;
                end else if (funct3 == 3'b100) begin
                    bad = 1'b1;
                end else begin
                    ctl.sysOp = rvIsaPkg::sysCsr;
                    ctl.regWr = 1'b1;
                    useRs1    = ~funct3[2];    // immediate forms take zimm
                    bad       = csrBad;
                end
            end
            default: bad = 1'b1;
        endcase
        ctl.illegal = bad | (instr[1:0] != 2'b11);
        // an illegal word traps and leaves no side effects
        if (ctl.illegal) begin
            ctl.regWr = 1'b0;
            ctl.memRd = 1'b0;
            ctl.memWr = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== immGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  rvIsaPkg::instrT  instr,
    input  rvIsaPkg::immFmtE immFmt,
    output rvIsaPkg::xlenT   imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immFmt)
            rvIsaPkg::immI: begin
                imm = {{52{sign}}, instr[31:20]};
            end
            rvIsaPkg::immS: begin
                imm = {{52{sign}}, instr[31:25], instr[11:7]};
            end
            rvIsaPkg::immB: begin
                imm = {{51{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvIsaPkg::immU: begin
                imm = {{32{sign}}, instr[31:12], 12'h000};
            end
            rvIsaPkg::immJ: begin
                imm = {{43{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;    // R type and system
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== regScoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module regScoreboard #(
    parameter int numRegs = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 issue,
    input  rvIsaPkg::regIdxT     issueRd,
    input  logic                 issueRegWr,
    input  idStagePkg::wbNoticeT wb,
    input  rvIsaPkg::regIdxT     rs1,
    input  rvIsaPkg::regIdxT     rs2,
    input  logic                 useRs1,
    input  logic                 useRs2,
    output logic                 srcHazard
);

    logic [numRegs-1:0] busy;
    logic               setEn;
    logic               rs1Busy;
    logic               rs2Busy;

    assign setEn = issue & issueRegWr & (issueRd != '0);    // x0 never busy

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (setEn && issueRd == rvIsaPkg::regIdxT'(i))
                    busy[i] <= 1'b1;    // set wins over wb
                else if (wb.valid && wb.rd == rvIsaPkg::regIdxT'(i))
                    busy[i] <= 1'b0;
            end
        end
    end

    // indices past numRegs read as free
    always_comb begin
        rs1Busy = 1'b0;
        rs2Busy = 1'b0;
        for (int i = 0; i < numRegs; i++) begin
            if (rs1 == rvIsaPkg::regIdxT'(i))
                rs1Busy = busy[i];
            if (rs2 == rvIsaPkg::regIdxT'(i))
                rs2Busy = busy[i];
        end
    end

    assign srcHazard = (useRs1 & rs1Busy) | (useRs2 & rs2Busy);

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage #(
    parameter rvIsaPkg::xlenT resetPc = 64'h0000_0000_8000_0000
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 inValid,
    input  idStagePkg::fetchPktT inPkt,
    output logic                 inBlock,
    input  logic                 flush,
    input  logic                 csrBad,
    input  logic                 outStall,
    input  logic                 srcHazard,
    output logic                 outValid,
    output idStagePkg::decodedT  outBundle,
    output rvIsaPkg::regIdxT     rs1,
    output rvIsaPkg::regIdxT     rs2,
    output logic                 useRs1,
    output logic                 useRs2,
    output logic                 issue
);

    logic                 heldValid;
    idStagePkg::fetchPktT heldPkt;
    logic                 accept;
    idStagePkg::decodedT  ctl;
    rvIsaPkg::immFmtE     immFmt;
    rvIsaPkg::xlenT       imm;
    logic                 decUseRs1;
    logic                 decUseRs2;

    assign outValid = heldValid & ~srcHazard & ~flush;
    assign issue    = outValid & ~outStall;
    // a flushed entry is dropped, so it never blocks
    assign inBlock  = heldValid & ~flush & (outStall | srcHazard);
    assign accept   = inValid & ~inBlock;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            heldValid <= 1'b0;
        end else if (accept) begin
            heldValid <= 1'b1;
        end else if (issue || flush) begin
            heldValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            heldPkt <= inPkt;
    end

    instrDecoder uDecoder (
        .instr  (heldPkt.instr),
        .csrBad (csrBad),
        .ctl    (ctl),
        .immFmt (immFmt),
        .useRs1 (decUseRs1),
        .useRs2 (decUseRs2)
    );

    immGen uImmGen (
        .instr  (heldPkt.instr),
        .immFmt (immFmt),
        .imm    (imm)
    );

    always_comb begin
        outBundle     = ctl;
        outBundle.pc  = heldValid ? heldPkt.pc : resetPc;    // boot pc when empty
        outBundle.rd  = heldPkt.instr[11:7];
        outBundle.imm = imm;
    end

    assign rs1    = ctl.rs1;
    assign rs2    = ctl.rs2;
    assign useRs1 = heldValid & decUseRs1;    // empty stage reads nothing
    assign useRs2 = heldValid & decUseRs2;

endmodule

`default_nettype wire

// ==== idTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module idTop #(
    parameter rvIsaPkg::xlenT resetPc = 64'h0000_0000_8000_0000,
    parameter int             numRegs = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 inValid,
    input  idStagePkg::fetchPktT inPkt,
    output logic                 inBlock,
    input  logic                 flush,
    input  logic                 csrBad,
    output logic                 outValid,
    output idStagePkg::decodedT  outBundle,
    input  logic                 outStall,
    input  idStagePkg::wbNoticeT wb
);

    rvIsaPkg::regIdxT rs1;
    rvIsaPkg::regIdxT rs2;
    logic             useRs1;
    logic             useRs2;
    logic             issue;
    logic             srcHazard;

    decodeStage #(
        .resetPc (resetPc)
    ) uStage (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inPkt     (inPkt),
        .inBlock   (inBlock),
        .flush     (flush),
        .csrBad    (csrBad),
        .outStall  (outStall),
        .srcHazard (srcHazard),
        .outValid  (outValid),
        .outBundle (outBundle),
        .rs1       (rs1),
        .rs2       (rs2),
        .useRs1    (useRs1),
        .useRs2    (useRs2),
        .issue     (issue)
    );

    regScoreboard #(
        .numRegs (numRegs)
    ) uScoreboard (
        .clk        (clk),
        .arstN      (arstN),
        .issue      (issue),
        .issueRd    (outBundle.rd),    // issue notice rides on the bundle
        .issueRegWr (outBundle.regWr),
        .wb         (wb),
        .rs1        (rs1),
        .rs2        (rs2),
        .useRs1     (useRs1),
        .useRs2     (useRs2),
        .srcHazard  (srcHazard)
    );

endmodule

`default_nettype wire

// ==== idTbModel.svh ====
`ifndef ID_TB_MODEL_SVH
`define ID_TB_MODEL_SVH

function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// {rs2 used, rs1 used} by format
function automatic logic [1:0] srcUse(rvIsaPkg::instrT w);
    case (w[6:2])
        5'b00000, 5'b00100, 5'b00110, 5'b11001: return 2'b01;
        5'b01000, 5'b01100, 5'b01110, 5'b11000: return 2'b11;
        5'b11100: return (w[14:12] inside {3'b001, 3'b010, 3'b011}) ? 2'b01 : 2'b00;
        default:  return 2'b00;
    endcase
endfunction

function automatic idStagePkg::decodedT refDecode(rvIsaPkg::xlenT pc, rvIsaPkg::instrT w,
                                                  logic csrBad);
    idStagePkg::decodedT d;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       word;
    logic       bad;
    d    = '0;
    f3   = w[14:12];
    f7   = w[31:25];
    word = w[3];
    bad  = 1'b0;
    d.pc  = pc;
    d.rd  = w[11:7];
    d.rs1 = w[19:15];
    d.rs2 = w[24:20];
    case (w[6:2])
        5'b00000: begin    // loads
            d.imm   = {{52{w[31]}}, w[31:20]};
            d.bSrc  = rvIsaPkg::bSrcImm;
            d.memRd = 1'b1;
            d.memOp = f3;
            d.regWr = 1'b1;
            bad     = (f3 == 3'b111);
        end
        5'b01000: begin    // stores
            d.imm   = {{52{w[31]}}, w[31:25], w[11:7]};
            d.bSrc  = rvIsaPkg::bSrcImm;
            d.memWr = 1'b1;
            d.memOp = f3;
            bad     = (f3 > 3'b011);
        end
        5'b00100, 5'b00110: begin
            d.imm    = {{52{w[31]}}, w[31:20]};
            d.bSrc   = rvIsaPkg::bSrcImm;
            d.regWr  = 1'b1;
            d.aluCtl = {1'b0, word, f7[5] & (f3 == 3'b101), f3};
            if (!word) begin
                if (f3 == 3'b001)
                    bad = (f7[6:1] != 6'd0);
                else if (f3 == 3'b101)
                    bad = !(f7[6:1] inside {6'b000000, 6'b010000});
            end else if (f3 == 3'b001) begin
                bad = (f7 != 7'd0);
            end else if (f3 == 3'b101) begin
                bad = !(f7 inside {7'b0000000, 7'b0100000});
            end else begin
                bad = (f3 != 3'b000);
            end
        end
        5'b01100, 5'b01110: begin
            d.regWr  = 1'b1;
            d.aluCtl = {f7[0], word, f7[5], f3};
            if (f7 == 7'b0000000)
                bad = word && !(f3 inside {3'b000, 3'b001, 3'b101});
            else if (f7 == 7'b0100000)
                bad = !(f3 inside {3'b000, 3'b101});
            else if (f7 == 7'b0000001)
                bad = word && (f3 inside {3'b001, 3'b010, 3'b011});
            else
                bad = 1'b1;
        end
        5'b01101: begin    // lui
            d.imm    = {{32{w[31]}}, w[31:12], 12'h000};
            d.bSrc   = rvIsaPkg::bSrcImm;
            d.regWr  = 1'b1;
            d.aluCtl = 6'b001111;
        end
        5'b00101: begin    // auipc
            d.imm   = {{32{w[31]}}, w[31:12], 12'h000};
            d.aSrc  = rvIsaPkg::aSrcPc;
            d.bSrc  = rvIsaPkg::bSrcImm;
            d.regWr = 1'b1;
        end
        5'b11011: begin    // jal
            d.imm    = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            d.aSrc   = rvIsaPkg::aSrcPc;
            d.bSrc   = rvIsaPkg::bSrcFour;
            d.branch = rvIsaPkg::brJal;
            d.regWr  = 1'b1;
        end
        5'b11001: begin    // jalr
            d.imm    = {{52{w[31]}}, w[31:20]};
            d.aSrc   = rvIsaPkg::aSrcPc;
            d.bSrc   = rvIsaPkg::bSrcFour;
            d.branch = rvIsaPkg::brJalr;
            d.regWr  = 1'b1;
            bad      = (f3 != 3'b000);
        end
        5'b11000: begin
            d.imm    = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            d.aluCtl = {5'b00001, f3[1]};
            case (f3)
                3'b000:  d.branch = rvIsaPkg::brEq;
                3'b001:  d.branch = rvIsaPkg::brNe;
                3'b100:  d.branch = rvIsaPkg::brLt;
                3'b101:  d.branch = rvIsaPkg::brGe;
                3'b110:  d.branch = rvIsaPkg::brLtu;
                3'b111:  d.branch = rvIsaPkg::brGeu;
                default: bad = 1'b1;
            endcase
        end
        5'b11100: begin
            d.bSrc    = rvIsaPkg::bSrcCsr;
            d.aluCtl  = 6'b001111;
            d.csrAddr = w[31:20];
            if (f3 == 3'b000) begin
                if (w == 32'h0000_0073)
                    d.sysOp = rvIsaPkg::sysEcall;
                else if (w == 32'h0010_0073)
                    d.sysOp = rvIsaPkg::sysEbreak;
                else if (w == 32'h3020_0073)
                    d.sysOp = rvIsaPkg::sysMret;
                else
                    bad = 1'b1;
            end else if (f3 == 3'b100) begin
                bad = 1'b1;
            end else begin
                d.sysOp = rvIsaPkg::sysCsr;
                d.regWr = 1'b1;
                bad     = csrBad;
            end
        end
        default: bad = 1'b1;
    endcase
    d.illegal = bad | (w[1:0] != 2'b11);
    if (d.illegal) begin    // traps write nothing
        d.regWr = 1'b0;
        d.memRd = 1'b0;
        d.memWr = 1'b0;
    end
    return d;
endfunction

`endif

// ==== idTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module idTb;

    `include "idTbModel.svh"

    logic                 clk;
    logic                 arstN;
    logic                 inValid;
    idStagePkg::fetchPktT inPkt;
    logic                 inBlock;
    logic                 flush;
    logic                 csrBad;
    logic                 outValid;
    idStagePkg::decodedT  outBundle;
    logic                 outStall;
    idStagePkg::wbNoticeT wb;

    idStagePkg::decodedT  expQ[$];
    rvIsaPkg::instrT      instrQ[$];
    logic [31:0]          busyModel;
    idStagePkg::decodedT  expB;
    rvIsaPkg::instrT      expW;
    logic [1:0]           uses;
    logic [31:0]          rng;
    string                curTest;
    int                   errors;
    int                   testErrStart;
    int                   tests;

    idTop #(
        .resetPc (64'h0000_0000_8000_0000),
        .numRegs (32)
    ) DUT (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inPkt     (inPkt),
        .inBlock   (inBlock),
        .flush     (flush),
        .csrBad    (csrBad),
        .outValid  (outValid),
        .outBundle (outBundle),
        .outStall  (outStall),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // compares issued bundles and tracks busy registers
    always @(posedge clk) begin
        if (!arstN) begin
            busyModel <= '0;
        end else begin
            if (wb.valid)
                busyModel[wb.rd] <= 1'b0;
            if (outValid && !outStall) begin
                if (expQ.size() == 0) begin
                    $display("ERROR %s: a bundle issued with nothing expected", curTest);
                    errors++;
                end else begin
                    expB = expQ.pop_front();
                    expW = instrQ.pop_front();
                    uses = srcUse(expW);
                    if ((uses[0] && busyModel[expB.rs1]) ||
                        (uses[1] && busyModel[expB.rs2])) begin
                        $display("ERROR %s: issued while a source was still busy", curTest);
                        errors++;
                    end
                    if (outBundle !== expB) begin
                        $display("FAILED %s expected %h actual %h", curTest, expB, outBundle);
                        errors++;
                    end
                    if (expB.regWr && expB.rd != 5'd0)
                        busyModel[expB.rd] <= 1'b1;    // set wins
                end
            end
        end
    end

    task automatic sendPkt(rvIsaPkg::instrT w, rvIsaPkg::xlenT pc, bit keep);
        int n;
        n = 0;
        @(posedge clk);
        inValid <= 1'b1;
        inPkt   <= '{instr: w, pc: pc};
        @(posedge clk);
        while (inBlock && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (n >= 100) begin
            $display("ERROR %s: packet was never accepted", curTest);
            errors++;
        end else if (keep) begin
            expQ.push_back(refDecode(pc, w, csrBad));
            instrQ.push_back(w);
        end
        inValid <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (expQ.size() != 0 && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (n >= 100) begin
            $display("ERROR %s: timed out waiting for issue", curTest);
            errors++;
            expQ.delete();
            instrQ.delete();
        end
    endtask

    task automatic retire(rvIsaPkg::regIdxT rd);
        @(posedge clk);
        wb <= '{valid: 1'b1, rd: rd};
        @(posedge clk);
        wb <= '0;
    endtask

    task automatic startTest(string name);
        curTest      = name;
        testErrStart = errors;
    endtask

    task automatic endTest();
        tests++;
        $display("%s done, %0d errors", curTest, errors - testErrStart);
    endtask

    function automatic rvIsaPkg::instrT legalWord(int grp, logic [31:0] r);
        rvIsaPkg::instrT w;
        logic [2:0]      f3;
        w  = r;
        f3 = r[13] ? 3'b101 : (r[12] ? 3'b001 : 3'b000);
        case (grp)
            0: begin
                w[6:0] = 7'b0000011;
                if (r[14:12] == 3'b111)
                    w[14:12] = 3'b011;
            end
            1: begin
                w[6:0] = 7'b0100011;
                w[14]  = 1'b0;
            end
            2: begin
                w[6:0] = 7'b0010011;
                if (w[14:12] == 3'b001)
                    w[31:26] = 6'd0;
                else if (w[14:12] == 3'b101)
                    w[31:26] = {1'b0, r[30], 4'b0000};
            end
            3: begin
                w[6:0]   = 7'b0011011;
                w[14:12] = f3;
                if (f3 == 3'b001)
                    w[31:25] = 7'd0;
                else if (f3 == 3'b101)
                    w[31:25] = {1'b0, r[30], 5'd0};
            end
            4, 5: begin
                w[6:0] = (grp == 4) ? 7'b0110011 : 7'b0111011;
                if (r[26:25] == 2'b00) begin
                    w[31:25] = 7'd0;
                    if (grp == 5)
                        w[14:12] = f3;
                end else if (r[26:25] == 2'b01) begin
                    w[31:25] = 7'd1;
                    if (grp == 5)
                        w[14:12] = r[14] ? {1'b1, r[13:12]} : 3'b000;
                end else begin
                    w[31:25] = 7'b0100000;
                    w[14:12] = r[14] ? 3'b101 : 3'b000;
                end
            end
            6: w[6:0] = 7'b0110111;
            7: w[6:0] = 7'b0010111;
            8: w[6:0] = 7'b1101111;
            9: begin
                w[6:0]   = 7'b1100111;
                w[14:12] = 3'b000;
            end
            10: begin
                w[6:0] = 7'b1100011;
                if (r[14:13] == 2'b01)
                    w[13] = 1'b0;
            end
            default: begin
                w[6:0] = 7'b1110011;
                if (r[14:12] == 3'b000)
                    w = r[21] ? 32'h3020_0073 : (r[20] ? 32'h0010_0073 : 32'h0000_0073);
                else if (r[14:12] == 3'b100)
                    w[14:12] = 3'b101;
            end
        endcase
        return w;
    endfunction

    initial begin
        rvIsaPkg::instrT bad[10];
        idStagePkg::decodedT snap;
        int grp;
        arstN     = 1'b0;
        inValid   = 1'b0;
        inPkt     = '0;
        flush     = 1'b0;
        csrBad    = 1'b0;
        outStall  = 1'b0;
        wb        = '0;
        errors    = 0;
        tests     = 0;
        rng       = 32'h9244_0d27;
        curTest   = "reset";
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        if (outValid || inBlock) begin
            $display("ERROR reset: stage not empty after reset");
            errors++;
        end

        startTest("random_legal");
        for (int i = 0; i < 120; i++) begin
            rng = xorshift(rng);
            grp = int'(rng % 12);
            rng = xorshift(rng);
            sendPkt(legalWord(grp, rng), 64'h8000_0000 + 64'(i * 4), 1'b1);
            drain();
            retire(inPkt.instr[11:7]);
        end
        endTest();

        startTest("immediates");
        for (int i = 0; i < 50; i++) begin
            rng = xorshift(rng);
            grp = (i % 5 == 0) ? 0 : (i % 5 == 1) ? 1 : (i % 5 == 2) ? 10 : (i % 5 == 3) ? 6 : 8;
            sendPkt(legalWord(grp, rng), 64'h9000_0000 + 64'(i * 4), 1'b1);
            drain();
            retire(inPkt.instr[11:7]);
        end
        endTest();

        startTest("illegal");
        bad = '{32'h0000_0010, 32'h0000_0007, 32'h0000_7003, 32'h0000_4023, 32'h0000_2063,
                32'h0000_1067, 32'h0400_1013, 32'h0400_0033, 32'h0020_0073, 32'h0000_4073};
        foreach (bad[i]) begin
            sendPkt(bad[i], 64'hA000_0000 + 64'(i * 4), 1'b1);
            drain();
        end
        csrBad <= 1'b1;
        sendPkt(32'h3401_1073, 64'hA000_1000, 1'b1);
        drain();
        csrBad <= 1'b0;
        endTest();

        startTest("hazard");
        sendPkt(32'h0010_0293, 64'hB000_0000, 1'b1);    // addi x5, x0, 1
        sendPkt(32'h0002_8333, 64'hB000_0004, 1'b1);    // add x6, x5, x0
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            if (outValid || !inBlock) begin
                $display("ERROR hazard: reader of x5 was not held");
                errors++;
            end
        end
        retire(5'd5);
        drain();
        sendPkt(32'h0010_0293, 64'hB000_0008, 1'b1);
        drain();
        sendPkt(32'h0010_0013, 64'hB000_000C, 1'b1);    // addi x0, x0, 1
        drain();
        sendPkt(32'h0000_03b3, 64'hB000_0010, 1'b1);    // add x7, x0, x0
        drain();
        sendPkt(32'h0002_8437, 64'hB000_0014, 1'b1);    // lui with x5 in rs1 field
        drain();
        for (int r = 1; r < 32; r++)
            retire(rvIsaPkg::regIdxT'(r));
        endTest();

        startTest("backpressure");
        outStall <= 1'b1;
        sendPkt(32'h0000_0013, 64'hC000_0000, 1'b1);
        @(posedge clk);
        snap    = outBundle;
        inValid <= 1'b1;
        inPkt   <= '{instr: 32'h0011_3023, pc: 64'hC000_0004};
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            if (!inBlock || outBundle !== snap) begin
                $display("ERROR backpressure: bundle moved or packet taken under stall");
                errors++;
            end
        end
        inValid  <= 1'b0;
        outStall <= 1'b0;
        sendPkt(32'h0011_3023, 64'hC000_0004, 1'b1);
        sendPkt(32'h0020_8063, 64'hC000_0008, 1'b1);
        drain();
        endTest();

        startTest("flush");
        outStall <= 1'b1;
        sendPkt(32'h0010_0493, 64'hD000_0000, 1'b0);    // addi x9 that gets flushed
        flush <= 1'b1;
        @(posedge clk);
        if (outValid) begin
            $display("ERROR flush: outValid high during flush");
            errors++;
        end
        flush    <= 1'b0;
        outStall <= 1'b0;
        repeat (3) @(posedge clk);
        sendPkt(32'h0004_8533, 64'hD000_0004, 1'b1);    // add x10, x9, x0
        drain();
        retire(5'd10);
        endTest();

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #2ms;
        $display("ERROR simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rvIsaPkg.sv
idStagePkg.sv
instrDecoder.sv
immGen.sv
regScoreboard.sv
decodeStage.sv
idTop.sv
+incdir+.
idTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# builds the decode-stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module idTb -f flist.f -o idTbSim --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/idTbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0
